// ==== hdl/rx_app_engine.sv ====
module rx_app_engine import rx_engine_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic cfg_valid,
    input flowid_t cfg_flowid,
    input buf_size_t cfg_bufsize,
    input req_count_t cfg_total_reqs,
    input logic cfg_should_copy,
    input logic enq_valid,
    input flowid_t enq_flowid,
    output logic msg_valid,
    output msg_type_e msg_type,
    output flowid_t msg_flowid,
    output buf_size_t msg_length,
    output buf_ptr_t msg_head_ptr,
    input logic notif_valid,
    input buf_ptr_t notif_head_ptr,
    output logic rd_req_valid,
    output flowid_t rd_req_flowid,
    output buf_ptr_t rd_req_offset,
    output buf_size_t rd_req_size,
    input logic rd_resp_valid,
    input payload_t rd_resp_data,
    input logic rd_resp_last,
    output logic app_data_valid,
    output payload_t app_data,
    output logic app_data_last
);

    recv_q_if q_if ();
    app_state_if st_if ();

    logic last_pkt;
    logic should_copy;
    logic store_inputs;
    logic store_app_state;
    logic store_notif;
    out_mux_sel_e out_mux_sel;

    // Payload is not buffered in the engine
    assign app_data_valid = rd_resp_valid;
    assign app_data = rd_resp_data;
    assign app_data_last = rd_resp_last;

    rx_recv_queue u_queue (
        .clk(clk),
        .arst_n(arst_n),
        .enq_valid(enq_valid),
        .enq_flowid(enq_flowid),
        .q(q_if.queue)
    );

    rx_app_state_store u_store (
        .clk(clk),
        .arst_n(arst_n),
        .cfg_valid(cfg_valid),
        .cfg_flowid(cfg_flowid),
        .cfg_bufsize(cfg_bufsize),
        .cfg_total_reqs(cfg_total_reqs),
        .cfg_should_copy(cfg_should_copy),
        .st(st_if.store)
    );

    rx_engine_ctrl u_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .q(q_if.engine),
        .state_wr(st_if.wr),
        .notif_valid(notif_valid),
        .rd_resp_valid(rd_resp_valid),
        .rd_resp_last(rd_resp_last),
        .last_pkt(last_pkt),
        .should_copy(should_copy),
        .store_inputs(store_inputs),
        .store_app_state(store_app_state),
        .store_notif(store_notif),
        .out_mux_sel(out_mux_sel),
        .msg_valid(msg_valid),
        .rd_req_valid(rd_req_valid),
        .requeue(q_if.requeue)
    );

    rx_engine_datap u_datap (
        .clk(clk),
        .arst_n(arst_n),
        .deq_flowid(q_if.deq_flowid),
        .rd_cntxt(st_if.rd_cntxt),
        .store_inputs(store_inputs),
        .store_app_state(store_app_state),
        .store_notif(store_notif),
        .out_mux_sel(out_mux_sel),
        .notif_head_ptr(notif_head_ptr),
        .state_rd_flowid(st_if.rd_flowid),
        .state_wr_flowid(st_if.wr_flowid),
        .state_wr_cntxt(st_if.wr_cntxt),
        .requeue_flowid(q_if.requeue_flowid),
        .msg_type(msg_type),
        .msg_flowid(msg_flowid),
        .msg_length(msg_length),
        .msg_head_ptr(msg_head_ptr),
        .rd_req_flowid(rd_req_flowid),
        .rd_req_offset(rd_req_offset),
        .rd_req_size(rd_req_size),
        .last_pkt(last_pkt),
        .should_copy(should_copy)
    );

endmodule

// ==== hdl/rx_app_state_store.sv ====
`include "rx_engine_consts.svh"

module rx_app_state_store import rx_engine_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic cfg_valid,
    input flowid_t cfg_flowid,
    input buf_size_t cfg_bufsize,
    input req_count_t cfg_total_reqs,
    input logic cfg_should_copy,
    app_state_if.store st
);

    app_cntxt_t cntxt_mem [`NUM_FLOWS];
    app_cntxt_t cfg_cntxt;

    // A fresh configuration starts with no requests done
    always_comb begin
        cfg_cntxt.bufsize = cfg_bufsize;
        cfg_cntxt.curr_reqs = '0;
        cfg_cntxt.total_reqs = cfg_total_reqs;
        cfg_cntxt.should_copy = cfg_should_copy;
    end

    assign st.rd_cntxt = cntxt_mem[st.rd_flowid];

    // Later assignment wins, so configuration overrides an engine write to the same flow
    always_ff @(posedge clk) begin
        if (st.wr) begin
            cntxt_mem[st.wr_flowid] <= st.wr_cntxt;
        end
        if (cfg_valid) begin
            cntxt_mem[cfg_flowid] <= cfg_cntxt;
        end
    end

    // A flow with zero requests would never stop being requeued
    a_total_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_valid |-> (cfg_total_reqs != '0));

endmodule

// ==== hdl/rx_engine_ctrl.sv ====
module rx_engine_ctrl import rx_engine_pkg::*; (
    input logic clk,
    input logic arst_n,
    recv_q_if.engine q,
    output logic state_wr,
    input logic notif_valid,
    input logic rd_resp_valid,
    input logic rd_resp_last,
    input logic last_pkt,
    input logic should_copy,
    output logic store_inputs,
    output logic store_app_state,
    output logic store_notif,
    output out_mux_sel_e out_mux_sel,
    output logic msg_valid,
    output logic rd_req_valid,
    output logic requeue
);

    rx_state_e state;
    rx_state_e state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        q.deq = 1'b0;
        store_inputs = 1'b0;
        store_app_state = 1'b0;
        store_notif = 1'b0;
        out_mux_sel = SEL_REQ;
        msg_valid = 1'b0;
        rd_req_valid = 1'b0;
        state_wr = 1'b0;
        requeue = 1'b0;

        case (state)
            IDLE: begin
                if (!q.empty) begin
                    q.deq = 1'b1;
                    store_inputs = 1'b1;
                    state_next = LOAD;
                end
            end
            LOAD: begin
                store_app_state = 1'b1;
                state_next = SEND_REQ;
            end
            SEND_REQ: begin
                msg_valid = 1'b1;
                state_next = WAIT_NOTIF;
            end
            WAIT_NOTIF: begin
                if (notif_valid) begin
                    store_notif = 1'b1;
                    state_next = should_copy ? RD_REQ : SEND_PTR;
                end
            end
            RD_REQ: begin
                rd_req_valid = 1'b1;
                state_next = WAIT_DATA;
            end
            WAIT_DATA: begin
                // Beats go straight out at the top, only the last one matters here
                if (rd_resp_valid && rd_resp_last) begin
                    state_next = SEND_PTR;
                end
            end
            SEND_PTR: begin
                msg_valid = 1'b1;
                out_mux_sel = SEL_PTR_UPDATE;
                state_next = WRITE_BACK;
            end
            WRITE_BACK: begin
                state_wr = 1'b1;
                requeue = !last_pkt;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // The TCP engine answers only a request that is still outstanding
    a_notif_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        notif_valid |-> (state == WAIT_NOTIF));

endmodule

// ==== hdl/rx_engine_datap.sv ====
module rx_engine_datap import rx_engine_pkg::*; (
    input logic clk,
    input logic arst_n,
    input flowid_t deq_flowid,
    input app_cntxt_t rd_cntxt,
    input logic store_inputs,
    input logic store_app_state,
    input logic store_notif,
    input out_mux_sel_e out_mux_sel,
    input buf_ptr_t notif_head_ptr,
    output flowid_t state_rd_flowid,
    output flowid_t state_wr_flowid,
    output app_cntxt_t state_wr_cntxt,
    output flowid_t requeue_flowid,
    output msg_type_e msg_type,
    output flowid_t msg_flowid,
    output buf_size_t msg_length,
    output buf_ptr_t msg_head_ptr,
    output flowid_t rd_req_flowid,
    output buf_ptr_t rd_req_offset,
    output buf_size_t rd_req_size,
    output logic last_pkt,
    output logic should_copy
);

    flowid_t flowid_reg;
    app_cntxt_t cntxt_reg;
    buf_ptr_t head_ptr_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flowid_reg <= '0;
            cntxt_reg <= '0;
            head_ptr_reg <= '0;
        end else begin
            if (store_inputs) begin
                flowid_reg <= deq_flowid;
            end
            if (store_app_state) begin
                cntxt_reg <= rd_cntxt;
            end
            if (store_notif) begin
                head_ptr_reg <= notif_head_ptr;
            end
        end
    end

    assign state_rd_flowid = flowid_reg;
    assign state_wr_flowid = flowid_reg;
    assign requeue_flowid = flowid_reg;

    always_comb begin
        state_wr_cntxt = cntxt_reg;
        state_wr_cntxt.curr_reqs = cntxt_reg.curr_reqs + 1'b1;
    end

    assign last_pkt = (cntxt_reg.curr_reqs == cntxt_reg.total_reqs - 1'b1);
    assign should_copy = cntxt_reg.should_copy;

    assign rd_req_flowid = flowid_reg;
    assign rd_req_offset = head_ptr_reg;
    assign rd_req_size = cntxt_reg.bufsize;

    assign msg_flowid = flowid_reg;
    assign msg_length = cntxt_reg.bufsize;

    // Pointer adjust moves the head past the consumed buffer, wrapping at the pointer width
    always_comb begin
        if (out_mux_sel == SEL_PTR_UPDATE) begin
            msg_type = MSG_ADJUST_PTR;
            msg_head_ptr = buf_ptr_t'(head_ptr_reg + cntxt_reg.bufsize);
        end else begin
            msg_type = MSG_REQ;
            msg_head_ptr = '0;
        end
    end

endmodule

// ==== hdl/rx_engine_ifs.sv ====
// Flow-id queue towards the engine
interface recv_q_if import rx_engine_pkg::*;;

    logic deq;
    flowid_t deq_flowid;
    logic empty;
    logic requeue;
    flowid_t requeue_flowid;

    modport queue (
        input deq, requeue, requeue_flowid,
        output deq_flowid, empty
    );

    modport engine (
        output deq, requeue, requeue_flowid,
        input deq_flowid, empty
    );

endinterface

// Application context store towards the engine
interface app_state_if import rx_engine_pkg::*;;

    flowid_t rd_flowid;
    app_cntxt_t rd_cntxt;
    logic wr;
    flowid_t wr_flowid;
    app_cntxt_t wr_cntxt;

    modport store (
        input rd_flowid, wr, wr_flowid, wr_cntxt,
        output rd_cntxt
    );

    modport engine (
        output rd_flowid, wr, wr_flowid, wr_cntxt,
        input rd_cntxt
    );

endinterface

// ==== hdl/rx_engine_pkg.sv ====
`include "rx_engine_consts.svh"

package rx_engine_pkg;

    typedef logic [`FLOWID_W-1:0] flowid_t;
    typedef logic [`PTR_W-1:0] buf_ptr_t;
    typedef logic [`SIZE_W-1:0] buf_size_t;
    typedef logic [`REQ_W-1:0] req_count_t;
    typedef logic [`DATA_W-1:0] payload_t;

    // Per-flow application context
    typedef struct packed {
        buf_size_t bufsize;
        req_count_t curr_reqs;
        req_count_t total_reqs;
        logic should_copy;
    } app_cntxt_t;

    typedef enum logic [1:0] {
        MSG_REQ = 2'd0,
        MSG_ADJUST_PTR = 2'd1
    } msg_type_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SEND_REQ,
        WAIT_NOTIF,
        RD_REQ,
        WAIT_DATA,
        SEND_PTR,
        WRITE_BACK
    } rx_state_e;

    // Chooses which message the datapath formats
    typedef enum logic {
        SEL_REQ,
        SEL_PTR_UPDATE
    } out_mux_sel_e;

endpackage

// ==== hdl/rx_recv_queue.sv ====
`include "rx_engine_consts.svh"

module rx_recv_queue import rx_engine_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic enq_valid,
    input flowid_t enq_flowid,
    recv_q_if.queue q
);

    localparam int IDX_W = $clog2(`NUM_FLOWS);
    localparam int CNT_W = IDX_W + 1;

    typedef logic [IDX_W-1:0] idx_t;

    function automatic idx_t incr(input idx_t p);
        return (p == idx_t'(`NUM_FLOWS - 1)) ? '0 : p + 1'b1;
    endfunction

    flowid_t mem [`NUM_FLOWS];
    idx_t head;
    idx_t tail;
    idx_t tail_p1;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    assign tail_p1 = incr(tail);
    assign q.deq_flowid = mem[head];
    assign q.empty = (count == '0);

    assign count_next = count + CNT_W'(enq_valid) + CNT_W'(q.requeue) - CNT_W'(q.deq);

    // The external entry goes in first when both arrive together
    always_ff @(posedge clk) begin
        if (enq_valid) begin
            mem[tail] <= enq_flowid;
        end
        if (q.requeue) begin
            mem[enq_valid ? tail_p1 : tail] <= q.requeue_flowid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (q.deq) begin
                head <= incr(head);
            end
            if (enq_valid && q.requeue) begin
                tail <= incr(tail_p1);
            end else if (enq_valid || q.requeue) begin
                tail <= tail_p1;
            end
            count <= count_next;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) q.deq |-> !q.empty);

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (enq_valid || q.requeue) |-> (count_next <= CNT_W'(`NUM_FLOWS)));

endmodule

// ==== include/rx_engine_consts.svh ====
`ifndef RX_ENGINE_CONSTS_SVH
`define RX_ENGINE_CONSTS_SVH

// Flow ids and the number of flows tracked by the engine
`define FLOWID_W 3
`define NUM_FLOWS 8

// Receive buffer pointer and per-request size
`define PTR_W 16
`define SIZE_W 16

// Request counters kept in the application context
`define REQ_W 8

// One payload beat from the receive buffer
`define DATA_W 32

`endif

// ==== rx_app_engine.f ====
+incdir+include
hdl/rx_engine_pkg.sv
hdl/rx_engine_ifs.sv
hdl/rx_recv_queue.sv
hdl/rx_app_state_store.sv
hdl/rx_engine_ctrl.sv
hdl/rx_engine_datap.sv
hdl/rx_app_engine.sv
test/tb_clock_gen.sv
test/rx_app_engine_tb.sv

// ==== test/rx_app_engine_input.txt ====
// flowid bufsize total_reqs should_copy head_ptr beats, all hex
// beats is the number of payload beats per read and only matters when should_copy is set
0 0040 2 1 0000 4
1 0100 1 0 1000 0
2 0020 3 1 fff0 2
3 0800 2 0 f900 0
4 0010 1 1 0200 1
5 0200 3 1 7ff0 3
6 0004 2 0 fffe 0
7 0080 1 1 3000 4

// ==== test/rx_app_engine_tb.sv ====
`include "rx_engine_consts.svh"

module rx_app_engine_tb import rx_engine_pkg::*;;

    localparam int COLS = 6;
    localparam int WAIT_LIMIT = 200;
    localparam int QUIET_CYCLES = 100;

    logic clk;
    logic arst_n;
    logic cfg_valid;
    flowid_t cfg_flowid;
    buf_size_t cfg_bufsize;
    req_count_t cfg_total_reqs;
    logic cfg_should_copy;
    logic enq_valid;
    flowid_t enq_flowid;
    logic msg_valid;
    msg_type_e msg_type;
    flowid_t msg_flowid;
    buf_size_t msg_length;
    buf_ptr_t msg_head_ptr;
    logic notif_valid;
    buf_ptr_t notif_head_ptr;
    logic rd_req_valid;
    flowid_t rd_req_flowid;
    buf_ptr_t rd_req_offset;
    buf_size_t rd_req_size;
    logic rd_resp_valid;
    payload_t rd_resp_data;
    logic rd_resp_last;
    logic app_data_valid;
    payload_t app_data;
    logic app_data_last;

    logic [15:0] vec_mem [`NUM_FLOWS * COLS];
    flowid_t file_order [`NUM_FLOWS];
    buf_size_t bufsize [`NUM_FLOWS];
    req_count_t total [`NUM_FLOWS];
    req_count_t remaining [`NUM_FLOWS];
    logic copy_en [`NUM_FLOWS];
    buf_ptr_t cur_ptr [`NUM_FLOWS];
    int beats [`NUM_FLOWS];
    bit enqueued [`NUM_FLOWS];
    payload_t beat_copy [$];
    integer seed = 26;
    int mismatch_count = 0;
    int failure_count = 0;
    int req_total = 0;
    bit enq_started = 1'b0;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(2)) u_clk (.clk(clk), .arst_n(arst_n));

    rx_app_engine uut (.*);

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic load_vectors();
        flowid_t f;
        $readmemh("test/rx_app_engine_input.txt", vec_mem);
        for (int i = 0; i < `NUM_FLOWS; i++) begin
            if ($isunknown(vec_mem[i * COLS + COLS - 1])) begin
                report_failure("input file holds fewer lines than flows");
            end else begin
                f = flowid_t'(vec_mem[i * COLS]);
                file_order[i] = f;
                bufsize[f] = vec_mem[i * COLS + 1];
                total[f] = req_count_t'(vec_mem[i * COLS + 2]);
                remaining[f] = total[f];
                copy_en[f] = vec_mem[i * COLS + 3][0];
                cur_ptr[f] = vec_mem[i * COLS + 4];
                beats[f] = vec_mem[i * COLS + 5];
                req_total += total[f];
            end
        end
    endtask

    task automatic wait_reset_release(output bit ok);
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (arst_n === 1'b1);
        if (!ok) begin
            report_failure("reset was never released");
        end
    endtask

    task automatic configure_flows();
        for (int i = 0; i < `NUM_FLOWS; i++) begin
            @(negedge clk);
            cfg_valid = 1'b1;
            cfg_flowid = file_order[i];
            cfg_bufsize = bufsize[file_order[i]];
            cfg_total_reqs = total[file_order[i]];
            cfg_should_copy = copy_en[file_order[i]];
        end
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic enqueue_flows();
        for (int i = 0; i < `NUM_FLOWS; i++) begin
            @(negedge clk);
            enq_valid = 1'b1;
            enq_flowid = file_order[i];
            enqueued[file_order[i]] = 1'b1;
            enq_started = 1'b1;
        end
        @(negedge clk);
        enq_valid = 1'b0;
    endtask

    // Returns at the edge where msg_valid is seen, so the fields are still valid
    task automatic wait_for_msg(input string what, output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (msg_valid === 1'b1) begin
                ok = 1'b1;
            end else if (rd_req_valid !== 1'b0) begin
                report_failure("read request while no read was due");
            end
        end
        if (!ok) begin
            report_failure({"timeout waiting for ", what});
        end
    endtask

    task automatic wait_for_rd_req(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (rd_req_valid === 1'b1) begin
                ok = 1'b1;
            end else if (msg_valid !== 1'b0) begin
                report_failure("message sent before the buffer read request");
            end
        end
        if (!ok) begin
            report_failure("timeout waiting for the buffer read request");
        end
    endtask

    task automatic drive_beats(input int n);
        payload_t expected;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rd_resp_valid = 1'b1;
            rd_resp_data = $random(seed);
            rd_resp_last = (i == n - 1);
            beat_copy.push_back(rd_resp_data);
            @(posedge clk);
            expected = beat_copy.pop_front();
            if (rd_req_valid !== 1'b0) begin
                report_failure("second read request for one notification");
            end
            if (app_data_valid !== 1'b1) begin
                report_mismatch("app_data_valid", 1, app_data_valid);
            end
            if (app_data !== expected) begin
                report_mismatch("app_data", expected, app_data);
            end
            if (app_data_last !== (i == n - 1)) begin
                report_mismatch("app_data_last", (i == n - 1), app_data_last);
            end
        end
        @(negedge clk);
        rd_resp_valid = 1'b0;
        rd_resp_last = 1'b0;
    endtask

    // Plays the TCP engine and the buffer for every request until all flows are done
    task automatic serve_requests();
        bit ok;
        flowid_t f;
        int delay;
        buf_ptr_t exp_ptr;
        int done;
        done = 0;
        while (done < req_total) begin
            wait_for_msg("a request message", ok);
            if (!ok) begin
                return;
            end
            f = msg_flowid;
            if (msg_type !== MSG_REQ) begin
                report_mismatch("request type", MSG_REQ, msg_type);
            end
            if (!enqueued[f] || remaining[f] == 0) begin
                report_failure($sformatf("request for flow %0d with no requests left", f));
                return;
            end
            if (msg_length !== bufsize[f]) begin
                report_mismatch("request length", bufsize[f], msg_length);
            end
            if (msg_head_ptr !== '0) begin
                report_mismatch("request head pointer", 0, msg_head_ptr);
            end
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(posedge clk);
            @(negedge clk);
            notif_valid = 1'b1;
            notif_head_ptr = cur_ptr[f];
            @(negedge clk);
            notif_valid = 1'b0;
            if (copy_en[f]) begin
                wait_for_rd_req(ok);
                if (!ok) begin
                    return;
                end
                if (rd_req_flowid !== f) begin
                    report_mismatch("read request flow", f, rd_req_flowid);
                end
                if (rd_req_offset !== cur_ptr[f]) begin
                    report_mismatch("read request offset", cur_ptr[f], rd_req_offset);
                end
                if (rd_req_size !== bufsize[f]) begin
                    report_mismatch("read request size", bufsize[f], rd_req_size);
                end
                drive_beats(beats[f]);
            end
            wait_for_msg("a pointer adjust message", ok);
            if (!ok) begin
                return;
            end
            // Head advances by one buffer and wraps at 16 bits
            exp_ptr = cur_ptr[f] + bufsize[f];
            if (msg_type !== MSG_ADJUST_PTR) begin
                report_mismatch("adjust type", MSG_ADJUST_PTR, msg_type);
            end
            if (msg_flowid !== f) begin
                report_mismatch("adjust flow", f, msg_flowid);
            end
            if (msg_head_ptr !== exp_ptr) begin
                report_mismatch("adjust head pointer", exp_ptr, msg_head_ptr);
            end
            cur_ptr[f] = exp_ptr;
            remaining[f]--;
            done++;
        end
    endtask

    task automatic check_silence();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk);
            if (msg_valid !== 1'b0 || rd_req_valid !== 1'b0) begin
                report_failure("strobe output after all flows finished");
            end
        end
    endtask

    always @(posedge clk) begin
        if (!enq_started && (msg_valid !== 1'b0 || rd_req_valid !== 1'b0
                || app_data_valid !== 1'b0)) begin
            report_failure(arst_n ? "strobe output before the first enqueue"
                                  : "strobe output during reset");
        end
    end

    initial begin
        bit ok;
        cfg_valid = 1'b0;
        cfg_flowid = '0;
        cfg_bufsize = '0;
        cfg_total_reqs = '0;
        cfg_should_copy = 1'b0;
        enq_valid = 1'b0;
        enq_flowid = '0;
        notif_valid = 1'b0;
        notif_head_ptr = '0;
        rd_resp_valid = 1'b0;
        rd_resp_data = '0;
        rd_resp_last = 1'b0;
        load_vectors();
        wait_reset_release(ok);
        if (ok && failure_count == 0) begin
            configure_flows();
            fork
                enqueue_flows();
                serve_requests();
            join
            check_silence();
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lands on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        #(RESET_CYCLES * PERIOD) arst_n = 1'b1;
    end

endmodule
